/* src/rv32e_pkg.sv */
// RV32E pipeline shared types, instruction encodings and core constants
`default_nettype none

package rv32e_pkg;

    localparam int XLEN     = 32;
    localparam int REG_AW   = 4;   // RV32E has sixteen registers
    localparam int NUM_REGS = 16;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // Major opcodes kept by this core, anything else decodes as a NOP
    typedef enum logic [6:0] {
        OP_REG   = 7'b0110011,
        OP_IMM   = 7'b0010011,
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011,
        OP_LUI   = 7'b0110111
    } opcode_e;

    // Encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_SRA  = 4'b1101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111
    } alu_op_e;

    localparam word_t RESET_PC   = 32'h8000_0000;
    localparam word_t NOP_INSTR  = 32'h0000_0013;  // addi x0, x0, 0
    localparam word_t INSTR_STEP = 32'd4;

endpackage

`default_nettype wire

/* src/core_if.sv */
// Pipeline register bundles passed from decode to execute and execute to memory
`timescale 1ns/1ps
`default_nettype none

interface id_ex_if;
    import rv32e_pkg::*;

    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    alu_op_e   alu_op;
    logic      use_imm;
    logic      is_lui;
    logic      mem_we;
    logic      mem_re;
    logic      reg_we;

    modport producer (output rs1_data, rs2_data, imm, rs1_addr, rs2_addr, rd_addr,
                      output alu_op, use_imm, is_lui, mem_we, mem_re, reg_we);
    modport consumer (input imm, rd_addr, alu_op, use_imm, is_lui, mem_we, mem_re, reg_we);
    modport monitor  (input rs1_data, rs2_data, rs1_addr, rs2_addr, rd_addr, mem_re);
endinterface

interface ex_mem_if;
    import rv32e_pkg::*;

    word_t     result;
    word_t     store_data;
    reg_addr_t rd_addr;
    logic      reg_we;
    logic      mem_we;
    logic      mem_re;

    modport producer (output result, store_data, rd_addr, reg_we, mem_we, mem_re);
    modport consumer (input result, store_data, rd_addr, reg_we, mem_we, mem_re);
    modport monitor  (input result, rd_addr, reg_we, mem_re);
endinterface

`default_nettype wire

/* src/reg_file.sv */
// Sixteen-entry register file, two combinational reads and x0 tied to zero
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire rv32e_pkg::reg_addr_t  rs1_addr_i,
    input  wire rv32e_pkg::reg_addr_t  rs2_addr_i,
    output rv32e_pkg::word_t           rs1_data_o,
    output rv32e_pkg::word_t           rs2_data_o,
    input  wire rv32e_pkg::reg_addr_t  wb_addr_i,
    input  wire rv32e_pkg::word_t      wb_data_i,
    input  wire                        wb_we_i
);
    import rv32e_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we_i && wb_addr_i != '0) begin
            regs[wb_addr_i] <= wb_data_i;  // Writes to x0 dropped
        end
    end

    // No same-cycle bypass, the delayed forward path covers it
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1_addr_i == '0 |-> rs1_data_o == '0) and (rs2_addr_i == '0 |-> rs2_data_o == '0));

endmodule

`default_nettype wire

/* src/hazard_unit.sv */
// Load-use stall detection and operand forwarding for the execute stage
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    id_ex_if.monitor                   id_ex,
    ex_mem_if.monitor                  ex_mem,
    input  wire rv32e_pkg::reg_addr_t  if_rs1_addr_i,
    input  wire rv32e_pkg::reg_addr_t  if_rs2_addr_i,
    input  wire rv32e_pkg::reg_addr_t  wb_addr_i,
    input  wire rv32e_pkg::word_t      wb_data_i,
    input  wire                        wb_we_i,
    input  wire rv32e_pkg::reg_addr_t  dly_addr_i,
    input  wire rv32e_pkg::word_t      dly_data_i,
    input  wire                        dly_we_i,
    output logic                       stall_o,
    output rv32e_pkg::word_t           fwd_a_o,
    output rv32e_pkg::word_t           fwd_b_o
);
    import rv32e_pkg::*;

    // Youngest producer wins, a load in EX/MEM has no data yet
    function automatic word_t fwd_select(input reg_addr_t src, input word_t reg_val);
        word_t sel;
        sel = reg_val;
        if (src != '0) begin
            if (ex_mem.reg_we && !ex_mem.mem_re && ex_mem.rd_addr == src) begin
                sel = ex_mem.result;
            end else if (wb_we_i && wb_addr_i == src) begin
                sel = wb_data_i;
            end else if (dly_we_i && dly_addr_i == src) begin
                sel = dly_data_i;
            end
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a_o = fwd_select(id_ex.rs1_addr, id_ex.rs1_data);
        fwd_b_o = fwd_select(id_ex.rs2_addr, id_ex.rs2_data);
    end

    // Load in ID/EX feeding the instruction right behind it
    assign stall_o = id_ex.mem_re && (id_ex.rd_addr != '0) &&
                     (id_ex.rd_addr == if_rs1_addr_i || id_ex.rd_addr == if_rs2_addr_i);

endmodule

`default_nettype wire

/* src/fetch_decode.sv */
// Fetch and decode stages with PC, IF/ID register and ID/EX register load
`timescale 1ns/1ps
`default_nettype none

module fetch_decode (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire rv32e_pkg::word_t      instr_data_i,
    input  wire                        stall_i,
    input  wire rv32e_pkg::word_t      rs1_data_i,
    input  wire rv32e_pkg::word_t      rs2_data_i,
    output rv32e_pkg::word_t           instr_addr_o,
    output rv32e_pkg::reg_addr_t       rs1_addr_o,
    output rv32e_pkg::reg_addr_t       rs2_addr_o,
    id_ex_if.producer                  id_ex
);
    import rv32e_pkg::*;

    word_t     pc_q;
    word_t     if_id_instr;
    opcode_e   opcode;
    logic [2:0] funct3;
    logic      alt_r;      // funct7[5] honoured for SUB and SRA
    logic      alt_i;      // Only SRAI uses it among immediates
    word_t     imm_i;
    word_t     imm_s;
    word_t     imm_u;
    word_t     dec_imm;
    alu_op_e   dec_alu_op;
    logic      dec_use_imm;
    logic      dec_is_lui;
    logic      dec_mem_we;
    logic      dec_mem_re;
    logic      dec_reg_we;

    assign instr_addr_o = pc_q;

    // PC and IF/ID both hold during a load-use stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q        <= RESET_PC;
            if_id_instr <= NOP_INSTR;
        end else if (!stall_i) begin
            pc_q        <= pc_q + INSTR_STEP;
            if_id_instr <= instr_data_i;
        end
    end

    assign opcode     = opcode_e'(if_id_instr[6:0]);
    assign funct3     = if_id_instr[14:12];
    assign rs1_addr_o = if_id_instr[18:15];  // Bit 19 ignored on RV32E
    assign rs2_addr_o = if_id_instr[23:20];
    assign alt_r      = (funct3 == 3'b000 || funct3 == 3'b101) ? if_id_instr[30] : 1'b0;
    assign alt_i      = (funct3 == 3'b101) ? if_id_instr[30] : 1'b0;

    assign imm_i = {{20{if_id_instr[31]}}, if_id_instr[31:20]};
    assign imm_s = {{20{if_id_instr[31]}}, if_id_instr[31:25], if_id_instr[11:7]};
    assign imm_u = {if_id_instr[31:12], 12'b0};

    always_comb begin
        dec_imm     = imm_i;
        dec_alu_op  = ALU_ADD;  // Address add for loads and stores
        dec_use_imm = 1'b0;
        dec_is_lui  = 1'b0;
        dec_mem_we  = 1'b0;
        dec_mem_re  = 1'b0;
        dec_reg_we  = 1'b0;
        case (opcode)
            OP_REG: begin
                dec_alu_op = alu_op_e'({alt_r, funct3});
                dec_reg_we = 1'b1;
            end
            OP_IMM: begin
                dec_alu_op  = alu_op_e'({alt_i, funct3});
                dec_use_imm = 1'b1;
                dec_reg_we  = 1'b1;
            end
            OP_LOAD: begin
                dec_use_imm = 1'b1;
                dec_mem_re  = 1'b1;
                dec_reg_we  = 1'b1;
            end
            OP_STORE: begin
                dec_imm     = imm_s;
                dec_use_imm = 1'b1;
                dec_mem_we  = 1'b1;
            end
            OP_LUI: begin
                dec_imm    = imm_u;
                dec_is_lui = 1'b1;
                dec_reg_we = 1'b1;
            end
            default: ;  // FENCE, system and unknown run as NOP
        endcase
    end

    // A bubble clears every ID/EX enable
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex.rs1_addr <= '0;
            id_ex.rs2_addr <= '0;
            id_ex.rd_addr  <= '0;
            id_ex.alu_op   <= ALU_ADD;
            id_ex.use_imm  <= 1'b0;
            id_ex.is_lui   <= 1'b0;
            id_ex.mem_we   <= 1'b0;
            id_ex.mem_re   <= 1'b0;
            id_ex.reg_we   <= 1'b0;
        end else if (stall_i) begin
            id_ex.rs1_addr <= '0;
            id_ex.rs2_addr <= '0;
            id_ex.rd_addr  <= '0;
            id_ex.alu_op   <= ALU_ADD;
            id_ex.use_imm  <= 1'b0;
            id_ex.is_lui   <= 1'b0;
            id_ex.mem_we   <= 1'b0;
            id_ex.mem_re   <= 1'b0;
            id_ex.reg_we   <= 1'b0;
        end else begin
            id_ex.rs1_addr <= rs1_addr_o;
            id_ex.rs2_addr <= rs2_addr_o;
            id_ex.rd_addr  <= if_id_instr[10:7];
            id_ex.alu_op   <= dec_alu_op;
            id_ex.use_imm  <= dec_use_imm;
            id_ex.is_lui   <= dec_is_lui;
            id_ex.mem_we   <= dec_mem_we;
            id_ex.mem_re   <= dec_mem_re;
            id_ex.reg_we   <= dec_reg_we;
        end
    end

    always_ff @(posedge clk) begin
        id_ex.rs1_data <= rs1_data_i;
        id_ex.rs2_data <= rs2_data_i;
        id_ex.imm      <= dec_imm;
    end

    // The bubble behind a load removes the hazard on the next cycle
    a_stall_single: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i |=> !stall_i);

    a_mem_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(id_ex.mem_we && id_ex.mem_re));

endmodule

`default_nettype wire

/* src/execute_stage.sv */
// Execute stage with operand select, ALU and EX/MEM register
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                    clk,
    input  wire                    rst_n,
    id_ex_if.consumer              id_ex,
    input  wire rv32e_pkg::word_t  fwd_a_i,
    input  wire rv32e_pkg::word_t  fwd_b_i,
    ex_mem_if.producer             ex_mem
);
    import rv32e_pkg::*;

    word_t      op_b;
    logic [4:0] shamt;
    word_t      alu_out;
    word_t      result;

    assign op_b  = id_ex.use_imm ? id_ex.imm : fwd_b_i;
    assign shamt = op_b[4:0];

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:  alu_out = fwd_a_i + op_b;
            ALU_SUB:  alu_out = fwd_a_i - op_b;
            ALU_SLL:  alu_out = fwd_a_i << shamt;
            ALU_SLT:  alu_out = {{(XLEN-1){1'b0}}, $signed(fwd_a_i) < $signed(op_b)};
            ALU_SLTU: alu_out = {{(XLEN-1){1'b0}}, fwd_a_i < op_b};
            ALU_XOR:  alu_out = fwd_a_i ^ op_b;
            ALU_SRL:  alu_out = fwd_a_i >> shamt;
            ALU_SRA:  alu_out = word_t'($signed(fwd_a_i) >>> shamt);
            ALU_OR:   alu_out = fwd_a_i | op_b;
            ALU_AND:  alu_out = fwd_a_i & op_b;
            default:  alu_out = '0;
        endcase
    end

    assign result = id_ex.is_lui ? id_ex.imm : alu_out;  // LUI bypasses the ALU

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem.rd_addr <= '0;
            ex_mem.reg_we  <= 1'b0;
            ex_mem.mem_we  <= 1'b0;
            ex_mem.mem_re  <= 1'b0;
        end else begin
            ex_mem.rd_addr <= id_ex.rd_addr;
            ex_mem.reg_we  <= id_ex.reg_we;
            ex_mem.mem_we  <= id_ex.mem_we;
            ex_mem.mem_re  <= id_ex.mem_re;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem.result     <= result;
        ex_mem.store_data <= fwd_b_i;  // Forwarded rs2 for SW
    end

    // Decoder must only ever emit defined ALU operations
    a_alu_legal: assert property (@(posedge clk) disable iff (!rst_n)
        id_ex.alu_op inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
                             ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND});

endmodule

`default_nettype wire

/* src/mem_writeback.sv */
// Memory access, writeback select, MEM/WB register and delayed writeback copy
`timescale 1ns/1ps
`default_nettype none

module mem_writeback (
    input  wire                        clk,
    input  wire                        rst_n,
    ex_mem_if.consumer                 ex_mem,
    input  wire rv32e_pkg::word_t      mem_data_i,
    output rv32e_pkg::word_t           mem_addr_o,
    output rv32e_pkg::word_t           mem_wdata_o,
    output logic                       mem_we_o,
    output logic                       mem_re_o,
    output rv32e_pkg::reg_addr_t       wb_addr_o,
    output rv32e_pkg::word_t           wb_data_o,
    output logic                       wb_we_o,
    output rv32e_pkg::reg_addr_t       dly_addr_o,
    output rv32e_pkg::word_t           dly_data_o,
    output logic                       dly_we_o
);
    import rv32e_pkg::*;

    word_t wb_sel;

    assign mem_addr_o  = ex_mem.result;
    assign mem_wdata_o = ex_mem.store_data;
    assign mem_we_o    = ex_mem.mem_we;
    assign mem_re_o    = ex_mem.mem_re;

    assign wb_sel = ex_mem.mem_re ? mem_data_i : ex_mem.result;  // Memory answers this cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_addr_o  <= '0;
            wb_we_o    <= 1'b0;
            dly_addr_o <= '0;
            dly_we_o   <= 1'b0;
        end else begin
            wb_addr_o  <= ex_mem.rd_addr;
            wb_we_o    <= ex_mem.reg_we;
            dly_addr_o <= wb_addr_o;
            dly_we_o   <= wb_we_o;
        end
    end

    // Delayed copy covers the register file write-then-read gap
    always_ff @(posedge clk) begin
        wb_data_o  <= wb_sel;
        dly_data_o <= wb_data_o;
    end

endmodule

`default_nettype wire

/* src/rv32e_core.sv */
// RV32E five-stage in-order core with separate instruction and data ports
`timescale 1ns/1ps
`default_nettype none

module rv32e_core (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire rv32e_pkg::word_t instr_data_i,
    input  wire rv32e_pkg::word_t mem_data_i,
    output wire rv32e_pkg::word_t instr_addr_o,
    output wire rv32e_pkg::word_t mem_addr_o,
    output wire rv32e_pkg::word_t mem_wdata_o,
    output wire                   mem_we_o,
    output wire                   mem_re_o
);
    import rv32e_pkg::*;

    reg_addr_t rs1_addr;   // Sources of the IF/ID instruction
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      stall;
    word_t     fwd_a;
    word_t     fwd_b;

    // Writeback and delayed writeback
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      wb_we;
    reg_addr_t dly_addr;
    word_t     dly_data;
    logic      dly_we;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();

    fetch_decode u_fetch_decode (
        .clk, .rst_n, .instr_data_i, .instr_addr_o,
        .stall_i(stall), .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .id_ex(id_ex)
    );

    reg_file u_reg_file (
        .clk, .rst_n,
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .wb_addr_i(wb_addr), .wb_data_i(wb_data), .wb_we_i(wb_we)
    );

    hazard_unit u_hazard_unit (
        .id_ex(id_ex), .ex_mem(ex_mem),
        .if_rs1_addr_i(rs1_addr), .if_rs2_addr_i(rs2_addr),
        .wb_addr_i(wb_addr), .wb_data_i(wb_data), .wb_we_i(wb_we),
        .dly_addr_i(dly_addr), .dly_data_i(dly_data), .dly_we_i(dly_we),
        .stall_o(stall), .fwd_a_o(fwd_a), .fwd_b_o(fwd_b)
    );

    execute_stage u_execute_stage (
        .clk, .rst_n, .id_ex(id_ex), .fwd_a_i(fwd_a), .fwd_b_i(fwd_b), .ex_mem(ex_mem)
    );

    mem_writeback u_mem_writeback (
        .clk, .rst_n, .ex_mem(ex_mem), .mem_data_i,
        .mem_addr_o, .mem_wdata_o, .mem_we_o, .mem_re_o,
        .wb_addr_o(wb_addr), .wb_data_o(wb_data), .wb_we_o(wb_we),
        .dly_addr_o(dly_addr), .dly_data_o(dly_data), .dly_we_o(dly_we)
    );

endmodule

`default_nettype wire

/* dv/iss_model.svh */
// Sequential RV32E instruction-set model and LCG used by the core testbench
`ifndef ISS_MODEL_SVH
`define ISS_MODEL_SVH

int unsigned lcg_state;

function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;  // Low LCG bits cycle too fast
endfunction

// Initial data memory contents, every word distinct
function automatic word_t fill_word(int idx);
    return {8'hC3, 8'(idx), 8'(idx * 37), 8'(~idx)};
endfunction

function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return {31'b0, $signed(a) < $signed(b)};
        3'b011:  return {31'b0, a < b};
        3'b100:  return a ^ b;
        3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

// Runs the program in order and records every store
task automatic run_model();
    word_t      rf [16];
    word_t      mem [64];
    word_t      instr;
    word_t      imm_i;
    word_t      addr;
    word_t      res;
    logic [3:0] rd;
    logic [3:0] rs1;
    logic [3:0] rs2;
    logic [2:0] f3;
    logic       wr;
    for (int k = 0; k < 16; k++) begin
        rf[4'(k)] = '0;
    end
    for (int k = 0; k < 64; k++) begin
        mem[6'(k)] = fill_word(k);
    end
    for (int i = 0; i < prog_len; i++) begin
        instr = prog[9'(i)];
        rd    = instr[10:7];
        rs1   = instr[18:15];
        rs2   = instr[23:20];
        f3    = instr[14:12];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        wr    = 1'b1;
        res   = '0;
        case (instr[6:0])
            OP_REG:  res = alu_ref(f3, instr[30], rf[rs1], rf[rs2]);
            OP_IMM:  res = alu_ref(f3, instr[30] && f3 == 3'b101, rf[rs1], imm_i);
            OP_LUI:  res = {instr[31:12], 12'b0};
            OP_LOAD: begin
                addr = rf[rs1] + imm_i;
                res  = mem[addr[7:2]];
            end
            OP_STORE: begin
                addr = rf[rs1] + {{20{instr[31]}}, instr[31:25], instr[11:7]};
                exp_addr.push_back(addr);
                exp_data.push_back(rf[rs2]);
                mem[addr[7:2]] = rf[rs2];
                wr = 1'b0;
            end
            default: wr = 1'b0;  // FENCE and system act as NOP
        endcase
        if (wr && rd != 4'd0) begin
            rf[rd] = res;
        end
    end
endtask

`endif

/* dv/tb_rv32e_core.sv */
// Testbench for the RV32E core, directed and random programs against an ISS model
`timescale 1ns/1ps
`default_nettype none

module tb_rv32e_core;
    import rv32e_pkg::*;

    logic  clk = 1'b0;
    logic  rst_n = 1'b0;
    word_t instr_data_i = NOP_INSTR;
    word_t mem_data_i = '0;
    word_t instr_addr_o;
    word_t mem_addr_o;
    word_t mem_wdata_o;
    logic  mem_we_o;
    logic  mem_re_o;

    word_t prog [512];
    int    prog_len = 0;
    word_t dmem [64];
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t last_pc = RESET_PC;
    int    pc_repeats = 0;
    int    exp_stalls = 0;

    `include "iss_model.svh"

    rv32e_core dut0 (
        .clk, .rst_n, .instr_data_i, .mem_data_i, .instr_addr_o,
        .mem_addr_o, .mem_wdata_o, .mem_we_o, .mem_re_o
    );

    initial begin
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic word_t enc_r(logic alt, int rs2, int rs1, logic [2:0] f3, int rd);
        return {1'b0, alt, 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), OP_REG};
    endfunction

    function automatic word_t enc_i(opcode_e op, logic [11:0] imm, int rs1, logic [2:0] f3,
                                    int rd);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, int rs2, int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t enc_u(logic [19:0] imm, int rd);
        return {imm, 5'(rd), OP_LUI};
    endfunction

    task automatic emit(word_t instr);
        prog[9'(prog_len)] = instr;
        prog_len++;
    endtask

    task automatic pad_nops(int n);
        for (int k = 0; k < n; k++) begin
            emit(NOP_INSTR);
        end
    endtask

    // Stores registers lo..hi to consecutive words with x0 as base
    task automatic store_range(int lo, int hi, int word_base);
        for (int r = lo; r <= hi; r++) begin
            emit(enc_s(12'((word_base + r - lo) * 4), r, 0));
        end
    endtask

    task automatic gen_random(int n);
        int         kind;
        int         rd;
        int         rs1;
        int         rs2;
        logic [2:0] f3;
        logic       alt;
        logic [11:0] imm;
        for (int i = 0; i < n; i++) begin
            kind = int'(lcg_next() % 10);
            rd   = int'(lcg_next() % 16);
            rs1  = int'(lcg_next() % 16);
            rs2  = int'(lcg_next() % 16);
            f3   = 3'(lcg_next());
            alt  = 1'(lcg_next());
            imm  = 12'(lcg_next());
            case (kind)
                0, 1, 2: emit(enc_r((f3 == 3'd0 || f3 == 3'd5) ? alt : 1'b0, rs2, rs1, f3, rd));
                3, 4: begin
                    if (f3 == 3'd1) imm = {7'b0, imm[4:0]};
                    else if (f3 == 3'd5) imm = {1'b0, alt, 5'b0, imm[4:0]};
                    emit(enc_i(OP_IMM, imm, rs1, f3, rd));
                end
                5:       emit(enc_u(20'((lcg_next() << 4) ^ lcg_next()), rd));
                6, 7:    emit(enc_i(OP_LOAD, 12'((lcg_next() % 64) * 4), 0, 3'b010, rd));
                default: emit(enc_s(12'((lcg_next() % 64) * 4), rs2, 0));
            endcase
        end
    endtask

    task automatic build_program();
        emit(enc_u(20'hF0F0F, 1));
        emit(enc_i(OP_IMM, 12'h8A5, 1, 3'b000, 1));
        emit(enc_i(OP_IMM, 12'h013, 0, 3'b000, 2));
        for (int f = 0; f < 8; f++) begin
            emit(enc_r(1'b0, 2, 1, 3'(f), 3 + f));
        end
        emit(enc_r(1'b1, 2, 1, 3'b000, 11));  // SUB
        emit(enc_r(1'b1, 2, 1, 3'b101, 12));  // SRA
        store_range(1, 12, 0);
        for (int f = 0; f < 8; f++) begin
            emit(enc_i(OP_IMM, (f == 1 || f == 5) ? 12'h007 : 12'hF3C, 1, 3'(f), 3 + f));
        end
        emit(enc_i(OP_IMM, 12'h407, 1, 3'b101, 11));  // SRAI
        emit(enc_i(OP_IMM, 12'h7FF, 1, 3'b011, 12));
        store_range(3, 12, 16);
        // Consumer d instructions behind its producer
        for (int d = 1; d <= 3; d++) begin
            for (int k = 0; k < 3; k++) begin
                emit(enc_i(OP_IMM, 12'(d * 16 + k), 5, 3'b000, 5));
                pad_nops(d - 1);
                emit(enc_r(1'b0, 5, 6, 3'b100, 6));
                pad_nops(d - 1);
            end
            emit(enc_s(12'(d * 4 + 128), 6, 0));
        end
        store_range(5, 6, 40);
        emit(enc_s(12'd200, 5, 0));
        emit(enc_i(OP_LOAD, 12'd200, 0, 3'b010, 7));
        emit(enc_r(1'b0, 7, 7, 3'b000, 8));  // Load-use on both sources
        emit(enc_i(OP_LOAD, 12'd204, 0, 3'b010, 9));
        emit(enc_s(12'd208, 9, 0));          // Store data straight from a load
        store_range(7, 8, 53);
        emit(enc_i(OP_IMM, 12'h055, 0, 3'b000, 0));
        emit(enc_u(20'hABCDE, 0));
        emit(enc_s(12'd224, 0, 0));
        emit(enc_r(1'b0, 1, 1, 3'b110, 0));
        emit(enc_i(OP_LOAD, 12'd0, 0, 3'b010, 0));
        emit(enc_s(12'd228, 0, 0));
        gen_random(160);
        store_range(1, 15, 0);
    endtask

    // Load in ID/EX whose rd matches a source field of the next instruction
    function automatic int count_load_use();
        int         n;
        logic [3:0] rd;
        n = 0;
        for (int i = 0; i + 1 < prog_len; i++) begin
            rd = prog[9'(i)][10:7];
            if (prog[9'(i)][6:0] == OP_LOAD && rd != 4'd0 &&
                (rd == prog[9'(i + 1)][18:15] || rd == prog[9'(i + 1)][23:20])) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic word_t fetch_instr(word_t addr);
        word_t idx;
        idx = (addr - RESET_PC) >> 2;
        return (idx < word_t'(prog_len)) ? prog[idx[8:0]] : NOP_INSTR;
    endfunction

    // Memories answer for the address seen after the rising edge
    always @(negedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < 64; k++) begin
                dmem[6'(k)] = fill_word(k);
            end
        end else begin
            if (mem_we_o) begin
                if (exp_addr.size() == 0) begin
                    $display("Store to %h arrived after the expected stores ran out", mem_addr_o);
                    abort_run();
                end else begin
                    check_word("mem_addr_o", mem_addr_o, exp_addr.pop_front());
                    check_word("mem_wdata_o", mem_wdata_o, exp_data.pop_front());
                    dmem[mem_addr_o[7:2]] = mem_wdata_o;
                end
            end
            if (instr_addr_o == last_pc) begin
                pc_repeats++;  // PC held by a stall
            end
            last_pc = instr_addr_o;
        end
        instr_data_i <= fetch_instr(instr_addr_o);
        // Inverted data outside a load so a missing read strobe shows up
        mem_data_i   <= mem_re_o ? dmem[mem_addr_o[7:2]] : ~dmem[mem_addr_o[7:2]];
    end

    initial begin
        @(posedge rst_n);
        repeat (4 * prog_len + 100) @(posedge clk);
        $display("Timeout with %0d expected stores never seen", exp_addr.size());
        abort_run();
    end

    initial begin
        lcg_state = 32'd35163;
        build_program();
        run_model();
        exp_stalls = count_load_use();
        repeat (3) @(negedge clk);
        check_word("instr_addr_o", instr_addr_o, RESET_PC);
        check_flag("mem_we_o", mem_we_o, 1'b0);
        check_flag("mem_re_o", mem_re_o, 1'b0);
        rst_n <= 1'b1;
        while (exp_addr.size() != 0) begin
            @(posedge clk);
        end
        repeat (20) @(negedge clk);  // Any stray store shows up here
        check_word("instr_addr_o repeat count", word_t'(pc_repeats), word_t'(exp_stalls));
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+dv
src/rv32e_pkg.sv
src/core_if.sv
src/reg_file.sv
src/hazard_unit.sv
src/fetch_decode.sv
src/execute_stage.sv
src/mem_writeback.sv
src/rv32e_core.sv
dv/tb_rv32e_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_rv32e_core
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TB PASSED" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
